/* sources.f */
hw/apb_pkg.sv
hw/apb_decoder.sv
hw/timer_regs.sv
hw/timer_core.sv
hw/scratch_ram.sv
hw/apb_timer_subsys.sv
test/apb_timer_properties.sv
test/tb_clock_gen.sv
test/tb_apb_timer.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_apb_timer
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL
PASS_MSG  := RESULT: PASS
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/apb_stimulus.txt */
# kind addr data strb prot exp_data exp_err, all hex
# W write, R read, P poll until (rdata & data) == exp_data, Q irq level in exp_data
W 1000 11223344 f 0 00000000 0
W 1004 a5a5a5a5 f 0 00000000 0
W 1000 ccddeeff 5 0 00000000 0
R 1000 00000000 0 0 11dd33ff 0
W 1004 5a000000 8 0 00000000 0
R 1004 00000000 0 0 5aa5a5a5 0
W 103c deadbeef f 0 00000000 0
W 103c 00001200 2 0 00000000 0
R 103c 00000000 0 0 dead12ef 0
R 1040 00000000 0 0 11dd33ff 0
W 3000 12345678 f 0 00000000 1
R 3000 00000000 0 0 00000000 1
R 1000 00000000 0 0 11dd33ff 0
W 0000 00000005 f 0 00000000 1
R 0000 00000000 0 0 00000000 0
W 0000 00000004 f 1 00000000 0
R 0000 00000000 0 0 00000004 0
W 0008 000000ff f 1 00000000 1
R 0008 00000000 0 0 00000000 0
W 0004 00000010 f 1 00000000 0
R 0004 00000000 0 0 00000010 0
W 0000 00000005 f 1 00000000 0
P 000c 00000001 0 0 00000001 0
Q 0000 00000000 0 0 00000001 0
R 0008 00000000 0 0 00000000 0
W 000c 00000001 f 0 00000000 0
Q 0000 00000000 0 0 00000000 0
R 000c 00000000 0 0 00000000 0
W 0004 00000018 f 1 00000000 0
W 0000 00000007 f 1 00000000 0
P 000c 00000001 0 0 00000001 0
W 000c 00000001 f 0 00000000 0
P 000c 00000001 0 0 00000001 0
Q 0000 00000000 0 0 00000001 0
W 0000 00000000 f 1 00000000 0
W 000c 00000001 f 0 00000000 0
Q 0000 00000000 0 0 00000000 0

/* test/tb_apb_timer.sv */
module tb_apb_timer;
    timeunit 1ns;
    timeprecision 1ps;

    import apb_pkg::*;

    localparam int READY_TIMEOUT = 8;
    localparam int POLL_LIMIT    = 100;
    localparam int RESET_TIMEOUT = 20;

    logic                     pclk;
    logic                     rst;
    logic [ADDR_WID-1:0]      paddr;
    logic [2:0]               pprot;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [DATA_WID-1:0]      pwdata;
    logic [DATA_BYTE_WID-1:0] pstrb;
    logic                     pready;
    logic [DATA_WID-1:0]      prdata;
    logic                     pslverr;
    logic                     irq;

    int checks;
    int mismatches;
    int failures;

    tb_clock_gen u_clock_gen (
        .pclk (pclk),
        .rst  (rst)
    );

    apb_timer_subsys UUT (
        .pclk    (pclk),
        .rst     (rst),
        .paddr   (paddr),
        .pprot   (pprot),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .irq     (irq)
    );

    task automatic check_value(input string name, input logic [DATA_WID-1:0] expected,
                               input logic [DATA_WID-1:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    // Only the scratch slot stalls, for one cycle
    function automatic int expected_wait_states(input logic [ADDR_WID-1:0] addr);
        if (addr[SLOT_MSB:SLOT_LSB] == SLOT_SCRATCH)
            return 1;
        else
            return 0;
    endfunction

    // Setup and access phases, driven on the falling edge
    task automatic apb_transfer(input logic write, input logic [ADDR_WID-1:0] addr,
                                input logic [DATA_WID-1:0] data,
                                input logic [DATA_BYTE_WID-1:0] strb,
                                input logic [2:0] prot, output logic [DATA_WID-1:0] rdata,
                                output logic err, output logic ok, output int waits);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        rdata  = '0;
        err    = 1'b0;
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = write ? data : '0;
        pstrb   = write ? strb : '0;
        pprot   = prot;
        @(negedge pclk);
        penable = 1'b1;
        while (!ok && cycles < READY_TIMEOUT)
        begin
            @(posedge pclk);
            if (pready)
            begin
                rdata = prdata;
                err   = pslverr;
                ok    = 1'b1;
            end
            else
                cycles++;
        end
        waits = cycles;
        if (!ok)
        begin
            $display("No pready from the DUT within %0d cycles at address %h",
                     READY_TIMEOUT, addr);
            failures++;
        end
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic poll_until(input logic [ADDR_WID-1:0] addr,
                              input logic [DATA_WID-1:0] mask,
                              input logic [DATA_WID-1:0] expected, input logic [2:0] prot);
        logic [DATA_WID-1:0] rdata;
        logic                err;
        logic                ok;
        logic                hit;
        int                  tries;
        int                  waits;
        hit   = 1'b0;
        tries = 0;
        while (!hit && tries < POLL_LIMIT)
        begin
            apb_transfer(1'b0, addr, '0, '0, prot, rdata, err, ok, waits);
            if (!ok)
                tries = POLL_LIMIT;
            else if ((rdata & mask) == expected)
                hit = 1'b1;
            else
                tries++;
        end
        if (!hit)
        begin
            $display("Polling address %h never returned %h under mask %h",
                     addr, expected, mask);
            failures++;
        end
    endtask

    initial
    begin
        int                       fd;
        int                       n;
        int                       cycles;
        int                       waits;
        string                    line;
        logic [63:0]              kind;
        logic [ADDR_WID-1:0]      f_addr;
        logic [DATA_WID-1:0]      f_data;
        logic [DATA_BYTE_WID-1:0] f_strb;
        logic [2:0]               f_prot;
        logic [DATA_WID-1:0]      f_exp;
        logic                     f_err;
        logic [DATA_WID-1:0]      rdata;
        logic                     err;
        logic                     ok;

        checks     = 0;
        mismatches = 0;
        failures   = 0;
        paddr      = '0;
        pprot      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        pstrb      = '0;

        @(posedge pclk);
        cycles = 0;
        while (rst && cycles < RESET_TIMEOUT)
        begin
            @(posedge pclk);
            cycles++;
        end
        if (rst)
        begin
            $display("Reset was never released");
            failures++;
        end

        fd = $fopen("test/apb_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file");
            failures++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() == 0 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%s %h %h %h %h %h %h", kind, f_addr, f_data, f_strb,
                            f_prot, f_exp, f_err);
                if (n != 7)
                    continue;
                case (kind[7:0])
                    "W":
                    begin
                        apb_transfer(1'b1, f_addr, f_data, f_strb, f_prot, rdata, err, ok,
                                     waits);
                        if (ok)
                        begin
                            check_value("pslverr", DATA_WID'(f_err), DATA_WID'(err));
                            check_value("wait states", DATA_WID'(expected_wait_states(f_addr)),
                                        DATA_WID'(waits));
                        end
                    end
                    "R":
                    begin
                        apb_transfer(1'b0, f_addr, '0, '0, f_prot, rdata, err, ok, waits);
                        if (ok)
                        begin
                            check_value("prdata", f_exp, rdata);
                            check_value("pslverr", DATA_WID'(f_err), DATA_WID'(err));
                            check_value("wait states", DATA_WID'(expected_wait_states(f_addr)),
                                        DATA_WID'(waits));
                        end
                    end
                    "P":
                        poll_until(f_addr, f_data, f_exp, f_prot);
                    "Q":
                    begin
                        @(posedge pclk);
                        check_value("irq", DATA_WID'(f_exp[0]), DATA_WID'(irq));
                    end
                    default:
                    begin
                        $display("Unknown operation kind in stimulus line: %s", line);
                        failures++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Checks: %0d, mismatches: %0d, other failures: %0d, assertion failures: %0d",
                 checks, mismatches, failures, UUT.u_properties.assert_failures);
        if (mismatches == 0 && failures == 0 && UUT.u_properties.assert_failures == 0
            && checks > 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic pclk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;

    // 20 ns period
    initial
    begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge pclk);
        @(negedge pclk);
        rst = 1'b0;
    end

endmodule

/* test/apb_timer_properties.sv */
module apb_timer_properties (
    input logic pclk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic irq
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_failures = 0;

    err_with_ready: assert property (@(posedge pclk) disable iff (rst) pslverr |-> pready)
    else
    begin
        $error("pslverr high while pready is low");
        assert_failures++;
    end

    ready_in_access: assert property (@(posedge pclk) disable iff (rst)
        pready |-> (psel && penable))
    else
    begin
        $error("pready high outside an access phase");
        assert_failures++;
    end

    // Registers clear on the first reset edge
    irq_low_in_reset: assert property (@(posedge pclk) rst |=> !irq)
    else
    begin
        $error("irq high during reset");
        assert_failures++;
    end

endmodule

bind apb_timer_subsys apb_timer_properties u_properties (
    .pclk    (pclk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
);

/* hw/apb_timer_subsys.sv */
module apb_timer_subsys (
    input  logic                               pclk,
    input  logic                               rst,
    input  logic [apb_pkg::ADDR_WID-1:0]       paddr,
    input  logic [2:0]                         pprot,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [apb_pkg::DATA_WID-1:0]       pwdata,
    input  logic [apb_pkg::DATA_BYTE_WID-1:0]  pstrb,
    output logic                               pready,
    output logic [apb_pkg::DATA_WID-1:0]       prdata,
    output logic                               pslverr,
    output logic                               irq
);
    import apb_pkg::*;

    logic                timer_sel;
    logic                scratch_sel;
    logic                timer_ready;
    logic [DATA_WID-1:0] timer_rdata;
    logic                timer_slverr;
    logic                scratch_ready;
    logic [DATA_WID-1:0] scratch_rdata;
    logic                scratch_slverr;

    // Register block to counter
    logic                run;
    logic                reload_mode;
    logic [DATA_WID-1:0] load_value;
    logic                load_strobe;
    logic [DATA_WID-1:0] count;
    logic                expired;

    apb_decoder u_decoder (
        .pclk           (pclk),
        .rst            (rst),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .timer_ready    (timer_ready),
        .timer_rdata    (timer_rdata),
        .timer_slverr   (timer_slverr),
        .scratch_ready  (scratch_ready),
        .scratch_rdata  (scratch_rdata),
        .scratch_slverr (scratch_slverr),
        .timer_sel      (timer_sel),
        .scratch_sel    (scratch_sel),
        .pready         (pready),
        .prdata         (prdata),
        .pslverr        (pslverr)
    );

    timer_regs u_timer_regs (
        .pclk        (pclk),
        .rst         (rst),
        .paddr       (paddr),
        .pprot       (pprot),
        .psel        (timer_sel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .count       (count),
        .expired     (expired),
        .pready      (timer_ready),
        .prdata      (timer_rdata),
        .pslverr     (timer_slverr),
        .run         (run),
        .reload_mode (reload_mode),
        .load_value  (load_value),
        .load_strobe (load_strobe),
        .irq         (irq)
    );

    timer_core u_timer_core (
        .pclk        (pclk),
        .rst         (rst),
        .run         (run),
        .reload_mode (reload_mode),
        .load_value  (load_value),
        .load_strobe (load_strobe),
        .count       (count),
        .expired     (expired)
    );

    scratch_ram u_scratch_ram (
        .pclk    (pclk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (scratch_sel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (scratch_ready),
        .prdata  (scratch_rdata),
        .pslverr (scratch_slverr)
    );

endmodule

/* hw/scratch_ram.sv */
module scratch_ram (
    input  logic                               pclk,
    input  logic                               rst,
    input  logic [apb_pkg::ADDR_WID-1:0]       paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [apb_pkg::DATA_WID-1:0]       pwdata,
    input  logic [apb_pkg::DATA_BYTE_WID-1:0]  pstrb,
    output logic                               pready,
    output logic [apb_pkg::DATA_WID-1:0]       prdata,
    output logic                               pslverr
);
    import apb_pkg::*;

    logic [DATA_WID-1:0]        mem [SCRATCH_WORDS];
    logic [SCRATCH_IDX_WID-1:0] idx;
    logic                       access;
    logic                       wait_q;
    logic [DATA_WID-1:0]        rdata_q;

    // Upper slot bits ignored, the words alias
    assign idx    = paddr[BYTE_OFF_WID +: SCRATCH_IDX_WID];
    assign access = psel && penable;

    assign pready  = access && wait_q;
    assign prdata  = rdata_q;
    assign pslverr = 1'b0;

    // High during the second access cycle only
    always_ff @(posedge pclk)
    begin
        if (rst)
            wait_q <= 1'b0;
        else
            wait_q <= access && !wait_q;
    end

    always_ff @(posedge pclk)
    begin
        if (access && !wait_q && !pwrite)
            rdata_q <= mem[idx];

        if (pready && pwrite)
        begin
            for (int i = 0; i < DATA_BYTE_WID; i++)
            begin
                if (pstrb[i])
                    mem[idx][8*i +: 8] <= pwdata[8*i +: 8];
            end
        end
    end

endmodule

/* hw/timer_core.sv */
module timer_core (
    input  logic                          pclk,
    input  logic                          rst,
    input  logic                          run,
    input  logic                          reload_mode,
    input  logic [apb_pkg::DATA_WID-1:0]  load_value,
    input  logic                          load_strobe,
    output logic [apb_pkg::DATA_WID-1:0]  count,
    output logic                          expired
);
    import apb_pkg::*;

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            count   <= '0;
            expired <= 1'b0;
        end
        else
        begin
            expired <= 1'b0;
            if (load_strobe)
                count <= load_value;
            else if (run)
            begin
                if (count == DATA_WID'(1))
                begin
                    count   <= '0;
                    expired <= 1'b1;
                end
                else if (count == '0)
                begin
                    // Stopped at zero unless auto-reload is on
                    if (reload_mode)
                        count <= load_value;
                end
                else
                begin
                    count <= count - DATA_WID'(1);
                end
            end
        end
    end

endmodule

/* hw/timer_regs.sv */
module timer_regs (
    input  logic                               pclk,
    input  logic                               rst,
    input  logic [apb_pkg::ADDR_WID-1:0]       paddr,
    input  logic [2:0]                         pprot,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [apb_pkg::DATA_WID-1:0]       pwdata,
    input  logic [apb_pkg::DATA_BYTE_WID-1:0]  pstrb,
    input  logic [apb_pkg::DATA_WID-1:0]       count,
    input  logic                               expired,
    output logic                               pready,
    output logic [apb_pkg::DATA_WID-1:0]       prdata,
    output logic                               pslverr,
    output logic                               run,
    output logic                               reload_mode,
    output logic [apb_pkg::DATA_WID-1:0]       load_value,
    output logic                               load_strobe,
    output logic                               irq
);
    import apb_pkg::*;

    logic [REG_ADDR_WID-1:0] offset;
    logic                    access;
    logic                    bad_access;
    logic                    wr_ok;
    logic                    ctrl_en_q;
    logic                    ctrl_reload_q;
    logic                    ctrl_irq_en_q;
    logic [DATA_WID-1:0]     load_q;
    logic                    status_q;
    logic                    load_strobe_q;

    assign offset = paddr[REG_ADDR_WID-1:0];
    assign access = psel && penable;

    // Unprivileged CTRL writes, COUNT writes and holes are refused
    always_comb
    begin
        case (offset)
            REG_CTRL:   bad_access = pwrite && !pprot[PPROT_PRIV];
            REG_LOAD:   bad_access = 1'b0;
            REG_COUNT:  bad_access = pwrite;
            REG_STATUS: bad_access = 1'b0;
            default:    bad_access = 1'b1;
        endcase
    end

    assign pready  = access;
    assign pslverr = access && bad_access;
    assign wr_ok   = access && pwrite && !bad_access;

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            ctrl_en_q     <= 1'b0;
            ctrl_reload_q <= 1'b0;
            ctrl_irq_en_q <= 1'b0;
            load_q        <= '0;
            status_q      <= 1'b0;
            load_strobe_q <= 1'b0;
        end
        else
        begin
            load_strobe_q <= wr_ok && (offset == REG_LOAD);

            // All control bits sit in byte lane 0
            if (wr_ok && (offset == REG_CTRL) && pstrb[0])
            begin
                ctrl_en_q     <= pwdata[CTRL_EN];
                ctrl_reload_q <= pwdata[CTRL_RELOAD];
                ctrl_irq_en_q <= pwdata[CTRL_IRQ_EN];
            end

            if (wr_ok && (offset == REG_LOAD))
            begin
                for (int i = 0; i < DATA_BYTE_WID; i++)
                begin
                    if (pstrb[i])
                        load_q[8*i +: 8] <= pwdata[8*i +: 8];
                end
            end

            // Sticky flag, a fresh expiry beats a clear
            if (expired)
                status_q <= 1'b1;
            else if (wr_ok && (offset == REG_STATUS) && pstrb[0] && pwdata[STATUS_EXPIRED])
                status_q <= 1'b0;
        end
    end

    always_comb
    begin
        prdata = '0;
        case (offset)
            REG_CTRL:
            begin
                prdata[CTRL_EN]     = ctrl_en_q;
                prdata[CTRL_RELOAD] = ctrl_reload_q;
                prdata[CTRL_IRQ_EN] = ctrl_irq_en_q;
            end
            REG_LOAD:   prdata = load_q;
            REG_COUNT:  prdata = count;
            REG_STATUS: prdata[STATUS_EXPIRED] = status_q;
            default:    prdata = '0;
        endcase
    end

    assign run         = ctrl_en_q;
    assign reload_mode = ctrl_reload_q;
    assign load_value  = load_q;
    assign load_strobe = load_strobe_q;
    assign irq         = status_q && ctrl_irq_en_q;

endmodule

/* hw/apb_decoder.sv */
module apb_decoder (
    input  logic                          pclk,
    input  logic                          rst,
    input  logic [apb_pkg::ADDR_WID-1:0]  paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          timer_ready,
    input  logic [apb_pkg::DATA_WID-1:0]  timer_rdata,
    input  logic                          timer_slverr,
    input  logic                          scratch_ready,
    input  logic [apb_pkg::DATA_WID-1:0]  scratch_rdata,
    input  logic                          scratch_slverr,
    output logic                          timer_sel,
    output logic                          scratch_sel,
    output logic                          pready,
    output logic [apb_pkg::DATA_WID-1:0]  prdata,
    output logic                          pslverr
);
    import apb_pkg::*;

    logic [SLOT_WID-1:0] slot;
    logic [SLOT_WID-1:0] slot_q;
    logic                access;

    assign slot   = paddr[SLOT_MSB:SLOT_LSB];
    assign access = psel && penable;

    assign timer_sel   = psel && (slot == SLOT_TIMER);
    assign scratch_sel = psel && (slot == SLOT_SCRATCH);

    // Slot captured in setup, held through the wait states
    always_ff @(posedge pclk)
    begin
        if (rst)
            slot_q <= SLOT_TIMER;
        else if (psel && !penable)
            slot_q <= slot;
    end

    always_comb
    begin
        case (slot_q)
            SLOT_TIMER:
            begin
                pready  = timer_ready;
                prdata  = timer_rdata;
                pslverr = timer_slverr;
            end
            SLOT_SCRATCH:
            begin
                pready  = scratch_ready;
                prdata  = scratch_rdata;
                pslverr = scratch_slverr;
            end
            default:
            begin
                // Unmapped, terminate at once with an error
                pready  = access;
                prdata  = '0;
                pslverr = access;
            end
        endcase
    end

endmodule

/* hw/apb_pkg.sv */
package apb_pkg;

    // Bus widths
    localparam int ADDR_WID      = 16;
    localparam int DATA_BYTE_WID = 4;
    localparam int DATA_WID      = 8 * DATA_BYTE_WID;
    localparam int BYTE_OFF_WID  = $clog2(DATA_BYTE_WID);

    // Slot field of the address
    localparam int SLOT_MSB = 15;
    localparam int SLOT_LSB = 12;
    localparam int SLOT_WID = SLOT_MSB - SLOT_LSB + 1;

    localparam logic [SLOT_WID-1:0] SLOT_TIMER   = SLOT_WID'(0);
    localparam logic [SLOT_WID-1:0] SLOT_SCRATCH = SLOT_WID'(1);

    // Timer register offsets inside its slot
    localparam int REG_ADDR_WID = SLOT_LSB;

    localparam logic [REG_ADDR_WID-1:0] REG_CTRL   = REG_ADDR_WID'('h0);
    localparam logic [REG_ADDR_WID-1:0] REG_LOAD   = REG_ADDR_WID'('h4);
    localparam logic [REG_ADDR_WID-1:0] REG_COUNT  = REG_ADDR_WID'('h8);
    localparam logic [REG_ADDR_WID-1:0] REG_STATUS = REG_ADDR_WID'('hC);

    // Control and status bits
    localparam int CTRL_EN        = 0;
    localparam int CTRL_RELOAD    = 1;
    localparam int CTRL_IRQ_EN    = 2;
    localparam int STATUS_EXPIRED = 0;

    localparam int PPROT_PRIV = 0;

    // Scratch memory
    localparam int SCRATCH_WORDS   = 16;
    localparam int SCRATCH_IDX_WID = $clog2(SCRATCH_WORDS);

endpackage
